/* files.f */
+incdir+hw
+incdir+tests
hw/aluPkg.sv
hw/barrelShifter.sv
hw/instrDecode.sv
hw/aluExecute.sv
hw/resultStage.sv
hw/execUnit.sv
tests/execUnitTb.sv

/* hw/aluExecute.sv */
`timescale 1ns/100ps
`default_nettype none

`include "alu_defines.svh"

module aluExecute
   import aluPkg::*;
(
   input  decoded_t dec,
   output word_t    value,
   output logic     ofl,
   output logic     zero
);

   logic  sub;
   word_t opA;
   word_t opBx;
   logic  cin;
   word_t sum;
   logic  carry;
   logic  oflSigned;
   logic  equal;
   logic  lessThan;
   word_t shiftOut;
   word_t reversed;

   // Swapped subtract gives opB - rs
   assign sub  = dec.op inside {SUB, SLT};
   assign opA  = sub ? dec.opB : dec.rsVal;
   assign opBx = sub ? ~dec.rsVal : dec.opB;
   assign cin  = sub;

   assign {carry, sum} = {1'b0, opA} + {1'b0, opBx} + {{`WORD_W{1'b0}}, cin};

   // Like signs in, other sign out
   assign oflSigned = (opA[`WORD_W-1] & opBx[`WORD_W-1] & ~sum[`WORD_W-1]) |
                      (~opA[`WORD_W-1] & ~opBx[`WORD_W-1] & sum[`WORD_W-1]);

   assign ofl  = dec.sign ? oflSigned : carry;
   assign zero = (dec.rsVal == '0);

   assign equal    = (dec.rsVal == dec.opB);
   assign lessThan = $signed(dec.rsVal) < $signed(dec.opB);

   // Mode is the low two opcode bits for ROL..SRA
   barrelShifter i_barrelShifter (
      .in     (dec.rsVal),
      .amount (dec.opB[3:0]),
      .mode   (shiftOp_e'(dec.op[1:0])),
      .out    (shiftOut)
   );

   always_comb begin
      for (int i = 0; i < `WORD_W; i++) begin
         reversed[i] = dec.rsVal[`WORD_W-1-i];
      end
   end

   always_comb begin
      case (dec.op)
         ADD, SUB:           value = sum;
         ST, LD, STU:        value = sum;   // Address only
         OR:                 value = dec.rsVal | dec.opB;
         AND:                value = dec.rsVal & dec.opB;
         ROL, SLL, ROR, SRA: value = shiftOut;
         BTR:                value = reversed;
         SEQ:                value = {{(`WORD_W-1){1'b0}}, equal};
         SLT:                value = {{(`WORD_W-1){1'b0}}, lessThan};
         SLE:                value = {{(`WORD_W-1){1'b0}}, lessThan | equal};
         SCO:                value = {{(`WORD_W-1){1'b0}}, carry};
         LBI:                value = dec.opB;
         SLBI:               value = {dec.rsVal[7:0], 8'h00} | dec.opB;
         BEQZ, BNEZ, BLTZ:   value = '0;
         SIIC, RTI:          value = '0;
         NOP, HALT:          value = '0;
         default:            value = 16'hbada;   // Unknown opcode marker
      endcase
   end

endmodule

`default_nettype wire

/* hw/aluPkg.sv */
`default_nettype none

`include "alu_defines.svh"

package aluPkg;

   typedef logic [`WORD_W-1:0] word_t;
   typedef logic [`WORD_W-1:0] instr_t;   // opcode, immSel, signSel, immediates

   // Numbering follows the ISA opcode table
   typedef enum logic [`OPC_W-1:0] {
      ADD  = 0,
      SUB  = 1,
      OR   = 2,
      AND  = 3,
      ROL  = 4,
      SLL  = 5,
      ROR  = 6,
      SRA  = 7,
      ST   = 8,
      LD   = 9,
      STU  = 10,
      BTR  = 11,
      SEQ  = 12,
      SLT  = 13,
      SLE  = 14,
      SCO  = 15,
      BEQZ = 16,
      BNEZ = 17,
      BLTZ = 18,
      LBI  = 19,
      SLBI = 20,
      SIIC = 26,
      RTI  = 27,
      NOP  = 28,
      HALT = 29
   } aluOp_e;

   // Same order as the low two bits of ROL..SRA
   typedef enum logic [1:0] {
      shRotl = 2'd0,
      shShl  = 2'd1,
      shRotr = 2'd2,
      shSra  = 2'd3
   } shiftOp_e;

   typedef struct packed {
      instr_t instr;
      word_t  rsVal;
      word_t  rtVal;
   } execReq_t;

   typedef struct packed {
      aluOp_e op;
      word_t  rsVal;
      word_t  opB;        // rtVal or extended immediate
      logic   sign;
      logic   isBranch;
      logic   illegal;
   } decoded_t;

   typedef struct packed {
      word_t value;
      logic  ofl;
      logic  zero;        // rs was zero
      logic  taken;
      logic  illegal;
   } execRes_t;

endpackage

`default_nettype wire

/* hw/alu_defines.svh */
`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

// Datapath width
`define WORD_W 16

// Opcode field, top five bits of the instruction
`define OPC_W   5
`define OPC_LSB 11

// Mode bits under the opcode
`define IMM_SEL_BIT  10
`define SIGN_SEL_BIT 9

// Immediate fields, both right aligned
`define IMM5_W 5
`define IMM8_W 8

`endif

/* hw/barrelShifter.sv */
`timescale 1ns/100ps
`default_nettype none

`include "alu_defines.svh"

module barrelShifter
   import aluPkg::*;
(
   input  word_t      in,
   input  logic [3:0] amount,
   input  shiftOp_e   mode,
   output word_t      out
);

   word_t stage [0:4];

   assign stage[0] = in;

   // Log shifter, stage i moves by 2**i when amount[i] is set
   for (genvar i = 0; i < 4; i++) begin : gStage
      localparam int Sh = 1 << i;
      word_t cur;
      word_t moved;

      assign cur = stage[i];

      always_comb begin
         case (mode)
            shRotl:  moved = {cur[`WORD_W-Sh-1:0], cur[`WORD_W-1 -: Sh]};
            shShl:   moved = {cur[`WORD_W-Sh-1:0], {Sh{1'b0}}};
            shRotr:  moved = {cur[Sh-1:0], cur[`WORD_W-1:Sh]};
            shSra:   moved = {{Sh{cur[`WORD_W-1]}}, cur[`WORD_W-1:Sh]};   // Sign fill
            default: moved = cur;
         endcase
      end

      assign stage[i+1] = amount[i] ? moved : cur;
   end

   assign out = stage[4];

endmodule

`default_nettype wire

/* hw/execUnit.sv */
`timescale 1ns/100ps
`default_nettype none

module execUnit
   import aluPkg::*;
(
   input  logic     clk,
   input  logic     rstN,
   input  logic     req,
   input  execReq_t reqData,
   output logic     ack,
   output execRes_t res
);

   logic     decValid;
   logic     busy;
   decoded_t dec;
   word_t    value;
   logic     ofl;
   logic     zero;

   instrDecode i_instrDecode (
      .clk      (clk),
      .rstN     (rstN),
      .req      (req),
      .reqData  (reqData),
      .busy     (busy),
      .decValid (decValid),
      .dec      (dec)
   );

   // Purely combinational between the two registers
   aluExecute i_aluExecute (
      .dec   (dec),
      .value (value),
      .ofl   (ofl),
      .zero  (zero)
   );

   resultStage i_resultStage (
      .clk      (clk),
      .rstN     (rstN),
      .decValid (decValid),
      .dec      (dec),
      .value    (value),
      .ofl      (ofl),
      .zero     (zero),
      .req      (req),
      .ack      (ack),
      .busy     (busy),
      .res      (res)
   );

endmodule

`default_nettype wire

/* hw/instrDecode.sv */
`timescale 1ns/100ps
`default_nettype none

`include "alu_defines.svh"

module instrDecode
   import aluPkg::*;
(
   input  logic     clk,
   input  logic     rstN,
   input  logic     req,
   input  execReq_t reqData,
   input  logic     busy,
   output logic     decValid,
   output decoded_t dec
);

   aluOp_e             opc;
   logic               immSel;
   logic               signSel;
   logic [`IMM5_W-1:0] imm5;
   logic [`IMM8_W-1:0] imm8;
   logic               signImm5;
   logic               accept;
   decoded_t           decNext;

   assign opc     = aluOp_e'(reqData.instr[`OPC_LSB +: `OPC_W]);
   assign immSel  = reqData.instr[`IMM_SEL_BIT];
   assign signSel = reqData.instr[`SIGN_SEL_BIT];
   assign imm5    = reqData.instr[`IMM5_W-1:0];
   assign imm8    = reqData.instr[`IMM8_W-1:0];

   // Arithmetic and compare immediates are signed
   assign signImm5 = opc inside {ADD, SUB, SEQ, SLT, SLE};

   // Busy covers both the decode slot and a raised ack
   assign accept = req & ~busy;

   always_comb begin
      decNext          = '0;
      decNext.op       = opc;
      decNext.rsVal    = reqData.rsVal;
      decNext.sign     = signSel;
      decNext.isBranch = opc inside {BEQZ, BNEZ, BLTZ};

      case (opc)
         ADD, SUB, OR, AND, ROL, SLL, ROR, SRA,
         ST, LD, STU, BTR, SEQ, SLT, SLE, SCO,
         BEQZ, BNEZ, BLTZ, LBI, SLBI,
         SIIC, RTI, NOP, HALT: decNext.illegal = 1'b0;
         default:              decNext.illegal = 1'b1;   // Jumps included
      endcase

      // Second operand
      if (opc == LBI) begin
         decNext.opB = {{(`WORD_W-`IMM8_W){imm8[`IMM8_W-1]}}, imm8};
      end else if (opc == SLBI) begin
         decNext.opB = {{(`WORD_W-`IMM8_W){1'b0}}, imm8};
      end else if (immSel) begin
         if (signImm5) begin
            decNext.opB = {{(`WORD_W-`IMM5_W){imm5[`IMM5_W-1]}}, imm5};
         end else begin
            decNext.opB = {{(`WORD_W-`IMM5_W){1'b0}}, imm5};
         end
      end else begin
         decNext.opB = reqData.rtVal;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         decValid <= 1'b0;
      end else begin
         decValid <= accept;   // One cycle per item
      end
   end

   // Held until the next accepted request
   always_ff @(posedge clk) begin
      if (accept) begin
         dec <= decNext;
      end
   end

endmodule

`default_nettype wire

/* hw/resultStage.sv */
`timescale 1ns/100ps
`default_nettype none

`include "alu_defines.svh"

module resultStage
   import aluPkg::*;
(
   input  logic     clk,
   input  logic     rstN,
   input  logic     decValid,
   input  decoded_t dec,
   input  word_t    value,
   input  logic     ofl,
   input  logic     zero,
   input  logic     req,
   output logic     ack,
   output logic     busy,
   output execRes_t res
);

   typedef enum logic [1:0] {
      idle,
      ackHigh,
      ackDrop
   } ackState_e;

   ackState_e state;
   ackState_e stateNext;
   logic      taken;

   // Branch outcome from rs only
   always_comb begin
      taken = 1'b0;
      if (dec.isBranch) begin
         case (dec.op)
            BEQZ:    taken = zero;
            BNEZ:    taken = ~zero;
            BLTZ:    taken = dec.rsVal[`WORD_W-1];
            default: taken = 1'b0;
         endcase
      end
   end

   always_comb begin
      stateNext = state;
      case (state)
         idle:    if (decValid) stateNext = ackHigh;
         ackHigh: if (!req) stateNext = ackDrop;   // Requester let go
         ackDrop: stateNext = idle;
         default: stateNext = idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         state <= idle;
         res   <= '0;
      end else begin
         state <= stateNext;
         if (decValid) begin
            res.value   <= value;
            res.ofl     <= ofl;
            res.zero    <= zero;
            res.taken   <= taken;
            res.illegal <= dec.illegal;
         end
      end
   end

   assign ack  = (state == ackHigh);
   assign busy = decValid | ack;   // No new capture until ack falls

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the execUnit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module execUnitTb -f files.f -Mdir obj_dir -o execUnitSim
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
   echo "Verilator build failed with status $buildStatus"
   exit 1
fi

./obj_dir/execUnitSim > sim.log 2>&1
simStatus=$?
cat sim.log

if grep -q "TEST FAIL" sim.log; then
   echo "Simulation reported a failure, see sim.log"
   exit 1
fi
if [ $simStatus -ne 0 ]; then
   echo "Simulation exited with status $simStatus"
   exit 1
fi
if ! grep -q "TEST PASS" sim.log; then
   echo "Simulation ended without a result line"
   exit 1
fi

echo "Simulation passed"
exit 0

/* tests/aluModel.svh */
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// True for every code listed in the opcode table
function automatic logic isLegalOpcode(logic [4:0] opc);
   return (opc <= 5'd20) || (opc >= 5'd26 && opc <= 5'd29);
endfunction

// Second operand after immediate selection
function automatic word_t modelOperandB(execReq_t r);
   logic [4:0] opc;
   logic [7:0] imm8;
   logic [4:0] imm5;
   opc  = r.instr[15:11];
   imm8 = r.instr[7:0];
   imm5 = r.instr[4:0];
   if (opc == LBI) begin
      return {{8{imm8[7]}}, imm8};
   end
   if (opc == SLBI) begin
      return {8'h00, imm8};
   end
   if (!r.instr[10]) begin
      return r.rtVal;
   end
   if (opc inside {ADD, SUB, SEQ, SLT, SLE}) begin
      return {{11{imm5[4]}}, imm5};   // Signed arithmetic immediates
   end
   return {11'd0, imm5};
endfunction

function automatic execRes_t expectedResult(execReq_t r);
   execRes_t   e;
   logic [4:0] opc;
   word_t      rs;
   word_t      b;
   int         n;
   int         sRes;
   logic       carry;
   logic       addCarry;
   e        = '0;
   opc      = r.instr[15:11];
   rs       = r.rsVal;
   b        = modelOperandB(r);
   n        = int'(b[3:0]);
   addCarry = (int'(rs) + int'(b)) > 65535;
   if (opc == SUB || opc == SLT) begin
      carry = (b >= rs);   // No borrow
      sRes  = int'($signed(b)) - int'($signed(rs));
   end else begin
      carry = addCarry;
      sRes  = int'($signed(rs)) + int'($signed(b));
   end
   case (opc)
      ADD, LD, ST, STU: e.value = rs + b;
      SUB:              e.value = b - rs;
      OR:               e.value = rs | b;
      AND:              e.value = rs & b;
      ROL:              e.value = (rs << n) | (rs >> (16 - n));
      SLL:              e.value = rs << n;
      ROR:              e.value = (rs >> n) | (rs << (16 - n));
      SRA:              e.value = word_t'($signed(rs) >>> n);
      BTR: begin
         for (int i = 0; i < 16; i++) begin
            e.value[i] = rs[15-i];
         end
      end
      SEQ:  e.value = {15'd0, rs == b};
      SLT:  e.value = {15'd0, $signed(rs) < $signed(b)};
      SLE:  e.value = {15'd0, $signed(rs) <= $signed(b)};
      SCO:  e.value = {15'd0, addCarry};
      LBI:  e.value = b;
      SLBI: e.value = {rs[7:0], 8'h00} | b;
      BEQZ: e.taken = (rs == 16'h0000);
      BNEZ: e.taken = (rs != 16'h0000);
      BLTZ: e.taken = rs[15];
      SIIC, RTI, NOP, HALT: e.value = '0;
      default: e.value = 16'hbada;
   endcase
   e.ofl     = r.instr[9] ? (sRes > 32767 || sRes < -32768) : carry;
   e.zero    = (rs == 16'h0000);
   e.illegal = !isLegalOpcode(opc);
   return e;
endfunction

`endif

/* tests/execUnitTb.sv */
`timescale 1ns/100ps
`default_nettype none

module execUnitTb
   import aluPkg::*;
();

   localparam int Period   = 4;
   localparam int MaxTrans = 258;   // 40 + 48 + 144 + 15 + 11

   localparam aluOp_e ArithOps [0:2] = '{ADD, SUB, SCO};
   localparam aluOp_e LogicOps [0:5] = '{OR, AND, ROL, SLL, ROR, SRA};
   localparam aluOp_e MiscOps [0:8] = '{SEQ, SLT, SLE, BTR, LBI, SLBI, LD, ST, STU};
   localparam aluOp_e BranchOps [0:2] = '{BEQZ, BNEZ, BLTZ};
   // Zero-result codes followed by the gaps in the opcode table
   localparam logic [4:0] OtherCodes [0:10] = '{5'd26, 5'd27, 5'd28, 5'd29, 5'd21,
                                               5'd22, 5'd23, 5'd24, 5'd25, 5'd30, 5'd31};

   logic        clk;
   logic        rstN;
   logic        req;
   execReq_t    reqData;
   logic        ack;
   execRes_t    res;
   logic [31:0] lcgState = 32'hdc45;

   execUnit i_execUnit (
      .clk     (clk),
      .rstN    (rstN),
      .req     (req),
      .reqData (reqData),
      .ack     (ack),
      .res     (res)
   );

   `include "aluModel.svh"

   initial begin
      clk = 1'b0;
      forever #(Period / 2) clk = ~clk;
   end

   initial begin
      #((16 + MaxTrans * 40) * Period);
      $display("Watchdog expired before all requests were acknowledged");
      $display("TEST FAIL");
      $fatal(1);
   end

   function automatic logic [31:0] nextRandom();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState;
   endfunction

   function automatic word_t pickOperand(logic [2:0] sel);
      logic [31:0] rnd;
      rnd = nextRandom();
      case (sel)
         3'd0:    return 16'h0000;
         3'd1:    return 16'h7fff;
         3'd2:    return 16'h8000;
         default: return rnd[31:16];
      endcase
   endfunction

   task automatic compareValue(string name, logic [31:0] expected, logic [31:0] actual);
      assert (actual == expected) else begin
         $display("error %s: expected %h, actual %h", name, expected, actual);
         $display("TEST FAIL");
         $fatal(1);
      end
   endtask

   task automatic ensureTrue(string what, logic cond);
      assert (cond) else begin
         $display("%s", what);
         $display("TEST FAIL");
         $fatal(1);
      end
   endtask

   // One full four-phase transfer with a random hold while ack is high
   task automatic runRequest(string group, logic [4:0] opc, word_t rs, word_t rt,
                             logic immSel);
      execReq_t    r;
      execRes_t    exp;
      logic [31:0] rnd;
      string       name;
      int          edges;
      int          hold;
      rnd     = nextRandom();
      r.instr = {opc, immSel, rnd[31], rnd[30], rnd[23:16]};   // Bit 8 is spare
      r.rsVal = rs;
      r.rtVal = rt;
      exp     = expectedResult(r);
      hold    = int'(rnd[28:26]);
      name    = $sformatf("%s op %0d", group, opc);
      reqData = r;
      req     = 1'b1;
      edges   = 0;
      while (!ack && edges < 8) begin
         @(posedge clk);
         #0.5;
         edges++;
      end
      compareValue({name, " ack latency"}, 32'd2, 32'(edges));
      compareValue(name, 32'(exp), 32'(res));
      repeat (hold) begin
         @(posedge clk);
         #0.5;
         ensureTrue("ack dropped while req was still high", ack);
         compareValue({name, " hold"}, 32'(exp), 32'(res));
      end
      req     = 1'b0;
      reqData = ~r;   // Must not disturb the held result
      @(posedge clk);
      #0.5;
      ensureTrue("ack did not fall one cycle after req dropped", !ack);
      compareValue({name, " after ack"}, 32'(exp), 32'(res));
   endtask

   initial begin
      logic [31:0] rnd;
      rstN    = 1'b0;
      req     = 1'b0;
      reqData = '0;
      repeat (16) begin
         @(posedge clk);
         #0.5;
         ensureTrue("ack or res not clear during reset", !ack && res == '0);
      end
      rstN = 1'b1;
      @(posedge clk);
      #0.5;
      ensureTrue("ack or res not clear after reset", !ack && res == '0);

      for (int i = 0; i < 40; i++) begin
         rnd = nextRandom();
         runRequest("arith", ArithOps[i % 3], pickOperand(rnd[31:29]),
                    pickOperand(rnd[28:26]), rnd[25]);
      end
      for (int op = 0; op < 6; op++) begin
         for (int imm = 0; imm < 2; imm++) begin
            repeat (4) begin
               rnd = nextRandom();
               runRequest("logic", LogicOps[op], pickOperand(rnd[31:29]),
                          pickOperand(rnd[28:26]), 1'(imm));
            end
         end
      end
      // Corner operands crossed with index 3 as the random pick
      for (int op = 0; op < 9; op++) begin
         for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
               rnd = nextRandom();
               runRequest("misc", MiscOps[op], pickOperand(3'(i)), pickOperand(3'(j)),
                          rnd[25]);
            end
         end
      end
      for (int op = 0; op < 3; op++) begin
         for (int i = 0; i < 5; i++) begin
            rnd = nextRandom();
            runRequest("branch", BranchOps[op], pickOperand(3'(i)), rnd[31:16], rnd[25]);
         end
      end
      for (int k = 0; k < 11; k++) begin
         rnd = nextRandom();
         runRequest("other", OtherCodes[k], pickOperand(rnd[31:29]), rnd[23:8], rnd[25]);
      end

      $display("TEST PASS");
      $finish;
   end

endmodule

`default_nettype wire
